/* verilog.f */
logic/n64c_pkg.sv
logic/ctrl_rpt_if.sv
logic/ctrl_sniffer.sv
logic/cfg_regs.sv
logic/frame_latch.sv
logic/igr_reset.sv
logic/n64c_top.sv
bench/tb_n64c.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and reports pass or fail by exit status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_n64c -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_n64c)
sim_rc=$?
echo "$sim_out"
if [ $sim_rc -ne 0 ]; then
  echo "simulation exited with status $sim_rc"
  exit 1
fi

if grep -qx "Simulation passed" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

/* bench/tb_n64c.sv */
// plays the console line, vsync and a wishbone master against n64c_top from a test table
`timescale 1ns/1ps
`default_nettype none

module tb_n64c import n64c_pkg::*; ();

  localparam int CLK_PERIOD  = 8;
  localparam int NUM_TESTS   = 6;
  localparam int RST_LEN     = 200;  // igr pulse length given to the DUT
  localparam int IDLE_CYCLES = 80;   // line high before each packet
  localparam int ACK_TIMEOUT = 16;

  typedef struct packed {
    logic [7:0]  cmd;       // console command byte
    logic        combo;     // force igr buttons into response
    logic        abort;     // stall line mid response
    logic [31:0] sys_cfg;
    logic [31:0] ppu;
    logic [1:0]  exp_vpll;
    logic [1:0]  exp_osd;
    logic        exp_rst;   // reset pulse expected
  } entry_t;

  logic       VCLK;
  logic       nSRST_4M;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  wb_adr_t    wb_adr;
  wb_dat_t    wb_dat_w;
  wb_dat_t    wb_dat_r;
  logic       wb_ack;
  logic       ctrl_line;
  logic       vsync_n;
  logic [1:0] manage_vpll;
  logic [1:0] osd_info;
  ppu_cfg_t   ppu_cfg_set;
  logic       nrst_out;

  entry_t stim [NUM_TESTS];
  int     errors;
  int     low_cycles;  // nrst_out low time per packet
  integer seed;

  n64c_top #(
    .RST_CYCLES (RST_LEN)
  ) dut0 (
    .VCLK        (VCLK),
    .nSRST_4M    (nSRST_4M),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .ctrl_line   (ctrl_line),
    .vsync_n     (vsync_n),
    .manage_vpll (manage_vpll),
    .osd_info    (osd_info),
    .ppu_cfg_set (ppu_cfg_set),
    .nrst_out    (nrst_out)
  );

  always #(CLK_PERIOD / 2) VCLK = ~VCLK;

  always @(negedge VCLK)
    if (nSRST_4M && !nrst_out)
      low_cycles = low_cycles + 1;

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  // inputs change 1 ns after the rising edge
  task automatic step(input int cycles);
    repeat (cycles) @(posedge VCLK);
    #1;
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
    errors++;
  endtask

  // one classic cycle held until ack
  task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                           output wb_dat_t rdat);
    int waited;
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    @(negedge VCLK);
    while (!wb_ack && waited < ACK_TIMEOUT) begin
      waited++;
      @(negedge VCLK);
    end
    if (!wb_ack) begin
      $display("no wishbone ack at address %0d within %0d cycles", adr, ACK_TIMEOUT);
      errors++;
    end
    rdat = wb_dat_r;  // valid while ack high
    step(1);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_reg(input wb_adr_t adr, input wb_dat_t dat);
    wb_dat_t unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic read_reg(input wb_adr_t adr, output wb_dat_t dat);
    bus_cycle(1'b0, adr, '0, dat);
  endtask

  task automatic put_bit(input logic b);
    ctrl_line = 1'b0;
    step(b ? 4 : 12);  // short low is a one
    ctrl_line = 1'b1;
    step(b ? 12 : 4);
  endtask

  task automatic put_stop(input int high_cycles);
    ctrl_line = 1'b0;
    step(4);
    ctrl_line = 1'b1;
    step(high_cycles);
  endtask

  // command msb first, response lsb first
  task automatic send_packet(input logic [7:0] cmd, input logic [31:0] resp,
                             input logic abort);
    ctrl_line = 1'b1;
    step(IDLE_CYCLES);
    for (int i = 7; i >= 0; i--)
      put_bit(cmd[i]);
    put_stop(12);  // console stop and turnaround
    for (int i = 0; i < 32; i++) begin
      if (abort && i == 16)
        step(70);  // line stuck high so the sniffer drops
      put_bit(resp[i]);
    end
    put_stop(8);
  endtask

  task automatic pulse_vsync();
    vsync_n = 1'b0;
    step(6);
    vsync_n = 1'b1;
    step(4);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int         t;
    int         n;
    int         errs_before;
    int         passed;
    int         failed;
    entry_t     e;
    wb_dat_t    rd;
    logic [31:0] resp;
    logic [31:0] exp_ctrl;
    logic [35:0] exp_ppu;
    logic [35:0] old_ppu;
    logic [1:0]  old_vpll;
    logic [1:0]  old_osd;
    logic        exp_new;

    VCLK       = 1'b0;
    nSRST_4M   = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    ctrl_line  = 1'b1;
    vsync_n    = 1'b1;
    errors     = 0;
    low_cycles = 0;
    seed       = 79236;
    passed     = 0;
    failed     = 0;
    exp_ctrl   = '0;
    old_vpll   = '0;
    old_osd    = '0;
    old_ppu    = '0;

    // cmd  combo abort sys_cfg  ppu  vpll osd rst
    stim[0] = '{8'h01, 1'b0, 1'b0, 32'h0000_0005, 32'h1234_5678, 2'b10, 2'b01, 1'b0};
    stim[1] = '{8'h01, 1'b1, 1'b0, 32'h0000_012e, 32'hcafe_0001, 2'b01, 2'b11, 1'b1};
    stim[2] = '{8'h03, 1'b0, 1'b0, 32'h0000_02d7, 32'h0f0f_a5a5, 2'b11, 2'b00, 1'b0};
    stim[3] = '{8'h01, 1'b0, 1'b1, 32'h0000_0020, 32'h8000_0000, 2'b00, 2'b00, 1'b0};
    stim[4] = '{8'h01, 1'b1, 1'b0, 32'h0000_000c, 32'h0000_ffff, 2'b00, 2'b11, 1'b0};
    stim[5] = '{8'h01, 1'b0, 1'b0, 32'h0000_0041, 32'h5555_aaaa, 2'b10, 2'b00, 1'b0};

    repeat (8) @(posedge VCLK);
    #1;
    nSRST_4M = 1'b1;
    step(2);

    // everything idle out of reset
    errs_before = errors;
    if (nrst_out !== 1'b1) report_mismatch("nrst_out after reset", nrst_out, 1);
    if (wb_ack !== 1'b0) report_mismatch("wb_ack after reset", wb_ack, 0);
    if (manage_vpll !== 2'b00) report_mismatch("manage_vpll after reset", manage_vpll, 0);
    if (osd_info !== 2'b00) report_mismatch("osd_info after reset", osd_info, 0);
    if (ppu_cfg_set !== '0) report_mismatch("ppu_cfg_set after reset", ppu_cfg_set, 0);
    if (errors == errs_before) begin
      $display("test reset: ok");
      passed++;
    end else begin
      $display("test reset: FAILED");
      failed++;
    end

    for (t = 0; t < NUM_TESTS; t++) begin
      errs_before = errors;
      e    = stim[t];
      resp = $random(seed);
      if (e.combo)
        resp[15:0] = IGR_COMBO;
      else if (resp[15:0] == IGR_COMBO)
        resp[0] = ~resp[0];  // keep random words off the combo
      exp_new = (e.cmd == POLL_CMD) && !e.abort;
      if (exp_new)
        exp_ctrl = resp;

      write_reg(ADR_SYS_CFG, e.sys_cfg);
      write_reg(ADR_PPU_CFG, e.ppu);
      read_reg(ADR_SYS_CFG, rd);
      if (rd !== e.sys_cfg) report_mismatch("sys_cfg readback", rd, e.sys_cfg);
      read_reg(ADR_PPU_CFG, rd);
      if (rd !== e.ppu) report_mismatch("ppu readback", rd, e.ppu);

      // still the previous frame's values
      if (manage_vpll !== old_vpll) report_mismatch("early manage_vpll", manage_vpll, old_vpll);
      if (osd_info !== old_osd) report_mismatch("early osd_info", osd_info, old_osd);
      if (ppu_cfg_set !== old_ppu) report_mismatch("early ppu_cfg_set", ppu_cfg_set, old_ppu);

      pulse_vsync();
      exp_ppu = {e.sys_cfg[8], e.sys_cfg[9], e.sys_cfg[7:6], e.ppu};  // pattern, swap, filter
      if (manage_vpll !== e.exp_vpll) report_mismatch("manage_vpll", manage_vpll, e.exp_vpll);
      if (osd_info !== e.exp_osd) report_mismatch("osd_info", osd_info, e.exp_osd);
      if (ppu_cfg_set !== exp_ppu) report_mismatch("ppu_cfg_set", ppu_cfg_set, exp_ppu);
      old_vpll = e.exp_vpll;
      old_osd  = e.exp_osd;
      old_ppu  = exp_ppu;

      low_cycles = 0;
      send_packet(e.cmd, resp, e.abort);
      // pulse already running a few cycles after the stop bit
      if (e.exp_rst && nrst_out !== 1'b0)
        report_mismatch("nrst_out after combo packet", nrst_out, 0);
      read_reg(ADR_CTRL, rd);
      if (rd !== exp_ctrl) report_mismatch("controller register", rd, exp_ctrl);
      read_reg(ADR_STATUS, rd);
      if (rd[0] !== exp_new) report_mismatch("new data flag", rd[0], exp_new);

      if (e.exp_rst) begin
        n = 0;
        while (!(low_cycles > 0 && nrst_out) && n < RST_LEN + 100) begin
          step(1);
          n++;
        end
        if (n >= RST_LEN + 100) begin
          $display("reset pulse never started or never ended in test %0d", t);
          errors++;
        end
        if (low_cycles != RST_LEN) report_mismatch("reset low cycles", low_cycles, RST_LEN);
      end else begin
        if (low_cycles != 0) report_mismatch("unexpected reset cycles", low_cycles, 0);
        if (nrst_out !== 1'b1) report_mismatch("nrst_out", nrst_out, 1);
      end

      pulse_vsync();  // frame start clears the flag
      read_reg(ADR_STATUS, rd);
      if (rd[0] !== 1'b0) report_mismatch("new data flag after vsync", rd[0], 0);

      if (errors == errs_before) begin
        $display("test %0d: ok", t);
        passed++;
      end else begin
        $display("test %0d: FAILED with %0d errors", t, errors - errs_before);
        failed++;
      end
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             passed + failed, passed, failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // watchdog

  initial begin
    repeat (NUM_TESTS * 1500) @(posedge VCLK);
    $display("watchdog expired after %0d cycles, run stopped", NUM_TESTS * 1500);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/n64c_top.sv */
// top level of the controller sniffer and video config block, ties the four blocks together
`timescale 1ns/1ps
`default_nettype none

module n64c_top import n64c_pkg::*; #(
  parameter int WAIT_BITS  = 6,
  parameter int RST_CYCLES = 1000
) (
  input  logic       VCLK,
  input  logic       nSRST_4M,
  // wishbone classic slave
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  wb_adr_t    wb_adr,
  input  wb_dat_t    wb_dat_w,
  output wb_dat_t    wb_dat_r,
  output logic       wb_ack,
  // console side
  input  logic       ctrl_line,  // idles high
  input  logic       vsync_n,
  output logic [1:0] manage_vpll,
  output logic [1:0] osd_info,
  output ppu_cfg_t   ppu_cfg_set,
  output logic       nrst_out
);

  sys_cfg_t sys_cfg;
  wb_dat_t  ppu_word;
  logic     frame_stb;
  logic     igr_enable;  // frame latched copy

  ctrl_rpt_if rpt_if ();

  //////////////////////////////////////////////////////////////////////////////
  // blocks

  ctrl_sniffer #(
    .WAIT_BITS (WAIT_BITS)
  ) sniff0 (
    .VCLK      (VCLK),
    .nSRST_4M  (nSRST_4M),
    .ctrl_line (ctrl_line),
    .rpt       (rpt_if.src)
  );

  cfg_regs regs0 (
    .VCLK      (VCLK),
    .nSRST_4M  (nSRST_4M),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .rpt       (rpt_if.snk),
    .frame_stb (frame_stb),
    .sys_cfg   (sys_cfg),
    .ppu_word  (ppu_word)
  );

  frame_latch latch0 (
    .VCLK        (VCLK),
    .nSRST_4M    (nSRST_4M),
    .vsync_n     (vsync_n),
    .sys_cfg     (sys_cfg),
    .ppu_word    (ppu_word),
    .frame_stb   (frame_stb),
    .manage_vpll (manage_vpll),
    .osd_info    (osd_info),
    .ppu_cfg_set (ppu_cfg_set),
    .igr_enable  (igr_enable)
  );

  igr_reset #(
    .RST_CYCLES (RST_CYCLES)
  ) igr0 (
    .VCLK       (VCLK),
    .nSRST_4M   (nSRST_4M),
    .rpt        (rpt_if.snk),
    .igr_enable (igr_enable),
    .nrst_out   (nrst_out)
  );

endmodule

`default_nettype wire

/* logic/igr_reset.sv */
// in-game reset, pulls the reset line low for a fixed time when the button combo is seen
`timescale 1ns/1ps
`default_nettype none

module igr_reset import n64c_pkg::*; #(
  parameter int RST_CYCLES = 1000
) (
  input  logic    VCLK,
  input  logic    nSRST_4M,
  ctrl_rpt_if.snk rpt,
  input  logic    igr_enable,
  output logic    nrst_out
);

  localparam int CNT_W = $clog2(RST_CYCLES + 1);

  logic [CNT_W-1:0] rst_cnt;  // cycles of pulse left
  logic             combo_hit;

  assign combo_hit = rpt.valid & igr_enable & (rpt.buttons == IGR_COMBO);

  always_ff @(posedge VCLK or negedge nSRST_4M) begin
    if (!nSRST_4M) begin
      rst_cnt  <= '0;
      nrst_out <= 1'b1;
    end else begin
      if (combo_hit) begin  // also restarts a running pulse
        rst_cnt  <= CNT_W'(RST_CYCLES);
        nrst_out <= 1'b0;
      end else if (rst_cnt > CNT_W'(1)) begin
        rst_cnt <= rst_cnt - 1'b1;
      end else if (rst_cnt == CNT_W'(1)) begin
        rst_cnt  <= '0;
        nrst_out <= 1'b1;  // pulse over
      end
    end
  end

  idle_means_released : assert property (
    @(posedge VCLK) disable iff (!nSRST_4M) (rst_cnt == '0) |-> nrst_out
  ) else $error("reset driven low with counter expired");

endmodule

`default_nettype wire

/* logic/frame_latch.sv */
// finds the vsync falling edge and applies the config words to the video outputs once per frame
`timescale 1ns/1ps
`default_nettype none

module frame_latch import n64c_pkg::*; (
  input  logic       VCLK,
  input  logic       nSRST_4M,
  input  logic       vsync_n,
  input  sys_cfg_t   sys_cfg,
  input  wb_dat_t    ppu_word,
  output logic       frame_stb,
  output logic [1:0] manage_vpll,
  output logic [1:0] osd_info,
  output ppu_cfg_t   ppu_cfg_set,
  output logic       igr_enable
);

  logic [1:0] vs_q;     // vsync history
  logic       vs_fall;
  logic       osd_on;   // osd shown and not muted

  assign vs_fall = vs_q[1] & ~vs_q[0];
  assign osd_on  = sys_cfg[CFG_SHOW_OSD] & ~sys_cfg[CFG_MUTE_OSD];

  always_ff @(posedge VCLK or negedge nSRST_4M) begin
    if (!nSRST_4M) begin
      vs_q        <= 2'b11;
      frame_stb   <= 1'b0;
      manage_vpll <= '0;
      osd_info    <= '0;
      ppu_cfg_set <= '0;
      igr_enable  <= 1'b0;
    end else begin
      vs_q      <= {vs_q[0], vsync_n};
      frame_stb <= vs_fall;  // one pulse per frame

      // new settings only take effect at frame start
      if (frame_stb) begin
        manage_vpll <= {sys_cfg[CFG_USE_VPLL], sys_cfg[CFG_TEST_VPLL]};
        osd_info[0] <= osd_on;
        osd_info[1] <= osd_on & sys_cfg[CFG_SHOW_LOGO];  // logo only inside osd
        ppu_cfg_set <= {sys_cfg[CFG_TESTPAT], sys_cfg[CFG_SWAP_RB],
                        sys_cfg[CFG_FILTER_HI:CFG_FILTER_LO], ppu_word};
        igr_enable  <= sys_cfg[CFG_IGR_EN];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/cfg_regs.sv */
// wishbone classic slave with the config words, last controller report and new-data status
`timescale 1ns/1ps
`default_nettype none

module cfg_regs import n64c_pkg::*; (
  input  logic    VCLK,
  input  logic    nSRST_4M,
  input  logic    wb_cyc,
  input  logic    wb_stb,
  input  logic    wb_we,
  input  wb_adr_t wb_adr,
  input  wb_dat_t wb_dat_w,
  output wb_dat_t wb_dat_r,
  output logic    wb_ack,
  ctrl_rpt_if.snk rpt,
  input  logic    frame_stb,
  output sys_cfg_t sys_cfg,
  output wb_dat_t ppu_word
);

  logic       wb_req;    // cycle seen this clock
  logic       wb_start;  // request not yet acked
  ctrl_word_t ctrl_reg;
  logic       new_data;

  assign wb_req   = wb_cyc & wb_stb;
  assign wb_start = wb_req & ~wb_ack;  // no back to back ack on held stb

  //////////////////////////////////////////////////////////////////////////////
  // bus side

  always_ff @(posedge VCLK or negedge nSRST_4M) begin
    if (!nSRST_4M) begin
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
      sys_cfg  <= '0;
      ppu_word <= '0;
    end else begin
      wb_ack <= wb_start;

      if (wb_start) begin  // read data lines up with ack
        case (wb_adr)
          ADR_CTRL:    wb_dat_r <= ctrl_reg;
          ADR_STATUS:  wb_dat_r <= {31'd0, new_data};
          ADR_SYS_CFG: wb_dat_r <= sys_cfg;
          ADR_PPU_CFG: wb_dat_r <= ppu_word;
          default:     wb_dat_r <= '0;
        endcase
      end

      // write lands in the ack cycle, ro addresses ignored
      if (wb_ack & wb_we) begin
        case (wb_adr)
          ADR_SYS_CFG: sys_cfg  <= wb_dat_w;
          ADR_PPU_CFG: ppu_word <= wb_dat_w;
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // controller report capture

  always_ff @(posedge VCLK or negedge nSRST_4M) begin
    if (!nSRST_4M) begin
      ctrl_reg <= '0;
      new_data <= 1'b0;
    end else begin
      if (rpt.valid)
        ctrl_reg <= {rpt.stick_y, rpt.stick_x, rpt.buttons};

      if (rpt.valid)
        new_data <= 1'b1;  // fresh report wins over frame clear
      else if (frame_stb)
        new_data <= 1'b0;
    end
  end

  // master holds the request through the ack cycle
  ack_inside_cycle : assert property (
    @(posedge VCLK) disable iff (!nSRST_4M) wb_ack |-> (wb_cyc & wb_stb)
  ) else $error("wishbone ack outside an active cycle");

endmodule

`default_nettype wire

/* logic/ctrl_sniffer.sv */
// decodes the console poll and controller response from the sniffed line, publishes each report
`timescale 1ns/1ps
`default_nettype none

module ctrl_sniffer import n64c_pkg::*; #(
  parameter int WAIT_BITS = 6
) (
  input  logic    VCLK,
  input  logic    nSRST_4M,
  input  logic    ctrl_line,
  ctrl_rpt_if.src rpt
);

  typedef enum logic [1:0] {
    ST_WAIT,  // idle until line has been high long enough
    ST_CMD,   // console command byte
    ST_RESP   // controller answer
  } sniff_state_t;

  sniff_state_t         state;
  logic [1:0]           line_q;     // line history
  logic                 line_fall;
  logic                 line_rise;
  logic                 line_edge;
  logic [WAIT_BITS-1:0] wait_cnt;   // time since last edge
  logic [WAIT_BITS-1:0] low_cnt;    // low time of current bit
  logic                 wait_sat;
  logic                 rx_bit;
  logic [4:0]           bit_cnt;
  logic [7:0]           cmd_sr;
  ctrl_word_t           resp_sr;
  ctrl_word_t           resp_word;  // shift reg incl. the bit ending now
  logic                 shift_cmd;
  logic                 shift_resp;
  logic                 publish;

  //////////////////////////////////////////////////////////////////////////////
  // edges and bit decision

  assign line_fall = line_q[1] & ~line_q[0];
  assign line_rise = ~line_q[1] & line_q[0];
  assign line_edge = line_fall | line_rise;
  assign wait_sat  = &wait_cnt;

  // short low then long high is a one
  assign rx_bit    = low_cnt < wait_cnt;
  assign resp_word = {rx_bit, resp_sr[31:1]};

  assign shift_cmd  = (state == ST_CMD) & line_fall & (bit_cnt != 5'd8);
  assign shift_resp = (state == ST_RESP) & line_fall & (bit_cnt != 5'd31);
  assign publish    = (state == ST_RESP) & line_fall & (bit_cnt == 5'd31);

  //////////////////////////////////////////////////////////////////////////////
  // control

  always_ff @(posedge VCLK or negedge nSRST_4M) begin
    if (!nSRST_4M) begin
      state     <= ST_WAIT;
      line_q    <= 2'b11;   // line idles high
      wait_cnt  <= '0;
      bit_cnt   <= '0;
      rpt.valid <= 1'b0;
    end else begin
      line_q    <= {line_q[0], ctrl_line};
      rpt.valid <= 1'b0;

      if (line_edge)
        wait_cnt <= '0;
      else if (!wait_sat)
        wait_cnt <= wait_cnt + 1'b1;  // saturating

      case (state)
        ST_WAIT: begin
          if (wait_sat & line_fall) begin  // first fall after long idle
            state   <= ST_CMD;
            bit_cnt <= '0;
          end
        end
        ST_CMD: begin
          if (line_fall) begin
            if (bit_cnt != 5'd8) begin
              bit_cnt <= bit_cnt + 1'b1;
            end else if (cmd_sr == POLL_CMD) begin  // response begins at this fall
              state   <= ST_RESP;
              bit_cnt <= '0;
            end else begin
              state <= ST_WAIT;                     // not ours, skip the rest
            end
          end
        end
        ST_RESP: begin
          if (line_fall) begin
            if (bit_cnt != 5'd31) begin
              bit_cnt <= bit_cnt + 1'b1;
            end else begin  // stop bit starts
              state     <= ST_WAIT;
              rpt.valid <= 1'b1;
            end
          end
        end
        default: state <= ST_WAIT;
      endcase

      if (wait_sat & ~line_edge)
        state <= ST_WAIT;  // line stuck, drop the packet
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // data path

  always_ff @(posedge VCLK) begin
    if (line_rise)
      low_cnt <= wait_cnt;
    if (shift_cmd)
      cmd_sr <= {cmd_sr[6:0], rx_bit};  // msb first
    if (shift_resp)
      resp_sr <= resp_word;             // lsb first
    if (publish) begin
      rpt.buttons <= resp_word[15:0];
      rpt.stick_x <= resp_word[23:16];
      rpt.stick_y <= resp_word[31:24];
    end
  end

  // consumers sample on a single cycle
  valid_single_cycle : assert property (
    @(posedge VCLK) disable iff (!nSRST_4M) rpt.valid |=> !rpt.valid
  ) else $error("report valid held for more than one cycle");

endmodule

`default_nettype wire

/* logic/ctrl_rpt_if.sv */
// decoded controller report, driven by the sniffer and read by the register block and reset logic
`timescale 1ns/1ps
`default_nettype none

interface ctrl_rpt_if import n64c_pkg::*; ();

  btn_t  buttons;  // bits 15..0 of the response
  axis_t stick_x;
  axis_t stick_y;
  logic  valid;    // single cycle, data held until next one

  modport src (
    output buttons, stick_x, stick_y, valid
  );

  modport snk (
    input buttons, stick_x, stick_y, valid
  );

endinterface

`default_nettype wire

/* logic/n64c_pkg.sv */
// shared widths, register map, button positions and reset combo, imported by every design unit
`default_nettype none

package n64c_pkg;

  // wishbone side
  typedef logic [1:0]  wb_adr_t;     // word address, four registers
  typedef logic [31:0] wb_dat_t;

  // controller report pieces
  typedef logic [31:0] ctrl_word_t;  // {y, x, buttons}, first bit in bit 0
  typedef logic [15:0] btn_t;
  typedef logic [7:0]  axis_t;

  typedef logic [31:0] sys_cfg_t;
  typedef logic [35:0] ppu_cfg_t;    // {testpat, swap_rb, filter[1:0], ppu word}

  // register map
  localparam wb_adr_t ADR_CTRL    = 2'd0;  // ro
  localparam wb_adr_t ADR_STATUS  = 2'd1;  // ro, bit 0 new data
  localparam wb_adr_t ADR_SYS_CFG = 2'd2;  // rw
  localparam wb_adr_t ADR_PPU_CFG = 2'd3;  // rw

  // sys_cfg fields
  localparam int CFG_USE_VPLL  = 0;
  localparam int CFG_TEST_VPLL = 1;
  localparam int CFG_SHOW_OSD  = 2;
  localparam int CFG_SHOW_LOGO = 3;
  localparam int CFG_MUTE_OSD  = 4;
  localparam int CFG_IGR_EN    = 5;
  localparam int CFG_FILTER_LO = 6;
  localparam int CFG_FILTER_HI = 7;
  localparam int CFG_TESTPAT   = 8;
  localparam int CFG_SWAP_RB   = 9;

  localparam logic [7:0] POLL_CMD = 8'h01;  // console status/button poll

  // button positions inside the 16 bit field
  localparam int BTN_A     = 0;
  localparam int BTN_B     = 1;
  localparam int BTN_Z     = 2;
  localparam int BTN_START = 3;
  localparam int BTN_L     = 10;
  localparam int BTN_R     = 11;

  localparam btn_t IGR_COMBO = btn_t'((1 << BTN_A) | (1 << BTN_B) | (1 << BTN_Z) |
                                      (1 << BTN_START) | (1 << BTN_L) | (1 << BTN_R));

endpackage

`default_nettype wire
